/* hw/pkt_arb_defs.svh */
// Sizing macros shared by the packet arbiter RTL and its package
// The channel count must be a power of two (2, 4 or 8), because the round-robin
// search relies on the channel number wrapping naturally
// The top PKT_ARB_IDX_BITS bits of ctl are overwritten with the source channel
`ifndef PKT_ARB_DEFS_SVH
`define PKT_ARB_DEFS_SVH

`define PKT_ARB_NUM_IN   4                                       // Number of input channels
`define PKT_ARB_IDX_BITS ($clog2(`PKT_ARB_NUM_IN))               // Width of a channel number

`define PKT_ARB_DAT_BYTS 2                                       // Data bytes per beat
`define PKT_ARB_DAT_BITS (`PKT_ARB_DAT_BYTS * 8)                 // Data bits per beat
`define PKT_ARB_MOD_BITS ($clog2(`PKT_ARB_DAT_BYTS))             // Width of the byte-count field

`define PKT_ARB_CTL_BITS 8                                       // Width of the control field
`define PKT_ARB_TAG_LSB  (`PKT_ARB_CTL_BITS - `PKT_ARB_IDX_BITS) // Lowest ctl bit of the tag

`define PKT_ARB_CNT_BITS 16                                      // Packet counter width, wraps

`endif

/* hw/pkt_arb_pkg.sv */
// Types shared by the packet arbiter blocks
// Valid is carried beside pkt_beat_t and never inside it
// Field widths come from the sizing macros, so the package follows any change there
`default_nettype none

`include "pkt_arb_defs.svh"

package pkt_arb_pkg;

  // One stream beat, without its valid
  typedef struct packed {
    logic                           sop;  // First beat of a packet
    logic                           eop;  // Last beat of a packet
    logic                           err;  // Error flag, passed through untouched
    logic [`PKT_ARB_MOD_BITS-1:0]   mod;  // Byte count of the last beat
    logic [`PKT_ARB_CTL_BITS-1:0]   ctl;  // Control field, top bits carry the channel tag
    logic [`PKT_ARB_DAT_BITS-1:0]   dat;  // Payload
  } pkt_beat_t;

  typedef enum logic {
    ARB_SEARCH = 1'b0,  // No packet owns the output
    ARB_LOCKED = 1'b1   // Selected channel owns the output until its eop leaves
  } arb_state_e;

  typedef enum logic [2:0] {
    REG_NOP       = 3'd0,  // Idle
    REG_WR_MASK   = 3'd1,  // Load the enable mask from the write data
    REG_RD_MASK   = 3'd2,  // Read back the enable mask
    REG_RD_COUNT  = 3'd3,  // Read the packet counter of the addressed channel
    REG_CLR_COUNT = 3'd4   // Clear the packet counter of the addressed channel
  } reg_op_e;

endpackage

`default_nettype wire

/* hw/pkt_in_stage.sv */
// One-beat register slice in front of the arbiter for a single channel
// Ready is "empty or leaving", so the slice sustains one beat per clock
// The channel number is stamped into the top ctl bits as the beat is captured
// CHAN must fit in PKT_ARB_IDX_BITS bits
`timescale 1ns/1ns
`default_nettype none

`include "pkt_arb_defs.svh"

module pkt_in_stage
  import pkt_arb_pkg::*;
#(
  parameter int unsigned CHAN = 0  // Channel number written into the tag
) (
  input  wire logic      i_clk,
  input  wire logic      i_rst,
  input  wire logic      i_val,   // Upstream valid
  input  wire pkt_beat_t i_beat,  // Upstream beat
  output logic           o_rdy,   // Upstream ready
  output logic           o_val,   // Valid towards the arbiter
  output pkt_beat_t      o_beat,  // Tagged beat towards the arbiter
  input  wire logic      i_rdy    // Ready from the arbiter, only set when selected
);

  localparam int IDX_W   = `PKT_ARB_IDX_BITS;
  localparam int TAG_LSB = `PKT_ARB_TAG_LSB;
  localparam logic [IDX_W-1:0] CHAN_TAG = IDX_W'(CHAN);

  logic      full_q;    // Slice holds a beat
  pkt_beat_t beat_q;    // Held beat, already tagged
  pkt_beat_t tag_beat;  // Incoming beat with the tag applied

  assign o_rdy  = ~full_q | i_rdy;  // Empty, or the held beat leaves on this edge
  assign o_val  = full_q;
  assign o_beat = beat_q;

  always_comb begin
    tag_beat = i_beat;
    tag_beat.ctl[TAG_LSB +: IDX_W] = CHAN_TAG;  // Overwrite the top ctl bits with our number
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      full_q <= 1'b0;
    end else if (o_rdy) begin
      full_q <= i_val;  // Refill or drain on the same edge
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      beat_q <= tag_beat;  // Payload only moves on a real transfer
    end
  end

endmodule

`default_nettype wire

/* hw/pkt_rr_arb.sv */
// Packet-locked round-robin arbiter with a combinational output multiplexer
// A channel that wins keeps the output until its eop beat is accepted
// The enable mask only affects which channel wins the next packet
// and never cuts a packet that is already locked
// Channel count must be a power of two so the cyclic search wraps for free
`timescale 1ns/1ns
`default_nettype none

`include "pkt_arb_defs.svh"

module pkt_rr_arb
  import pkt_arb_pkg::*;
(
  input  wire logic                           i_clk,
  input  wire logic                           i_rst,
  input  wire logic      [`PKT_ARB_NUM_IN-1:0] i_val,       // Valid from each stage
  input  wire pkt_beat_t [`PKT_ARB_NUM_IN-1:0] i_beat,      // Beat from each stage
  output logic           [`PKT_ARB_NUM_IN-1:0] o_rdy,       // Ready back to each stage
  input  wire logic      [`PKT_ARB_NUM_IN-1:0] i_en_mask,   // Channels allowed to start a packet
  output logic                                o_val,       // Output valid
  output pkt_beat_t                           o_beat,      // Output beat
  input  wire logic                           i_rdy,       // Output ready
  output logic                                o_pkt_done,  // Pulse when an eop beat leaves
  output logic           [`PKT_ARB_IDX_BITS-1:0] o_pkt_chan // Channel of that eop beat
);

  localparam int NUM_IN = `PKT_ARB_NUM_IN;
  localparam int IDX_W  = `PKT_ARB_IDX_BITS;

  arb_state_e       state_q;  // Search or locked
  logic [IDX_W-1:0] sel_q;    // Last winner, or the current owner when locked
  logic [IDX_W-1:0] cand;     // Channel under test in the search loop
  logic [IDX_W-1:0] nxt_idx;  // First eligible channel after sel_q
  logic             found;    // Some channel is eligible to start a packet
  logic [IDX_W-1:0] mux_idx;  // Channel currently driving the output
  logic             leaving;  // Output beat transfers on this edge
  logic             eop_out;  // An eop beat transfers on this edge

  // Walk backwards so the first eligible channel after sel_q wins; sel_q itself comes last
  always_comb begin
    found   = 1'b0;
    nxt_idx = sel_q;
    cand    = sel_q;
    for (int i = NUM_IN; i >= 1; i--) begin
      cand = sel_q + i[IDX_W-1:0];  // i == NUM_IN wraps back to sel_q
      if (i_val[cand] && i_en_mask[cand]) begin
        found   = 1'b1;
        nxt_idx = cand;
      end
    end
  end

  assign mux_idx = (state_q == ARB_LOCKED) ? sel_q : nxt_idx;  // Search winner shows at once
  assign o_beat  = i_beat[mux_idx];
  assign o_val   = (state_q == ARB_LOCKED) ? i_val[sel_q] : found;
  assign leaving = o_val & i_rdy;
  assign eop_out = leaving & o_beat.eop;

  always_comb begin
    o_rdy          = '0;
    o_rdy[mux_idx] = leaving;  // Only the selected stage ever sees ready
  end

  assign o_pkt_done = eop_out;
  assign o_pkt_chan = mux_idx;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= ARB_SEARCH;
      sel_q   <= '0;
    end else begin
      case (state_q)
        ARB_SEARCH: begin
          if (found) begin
            sel_q <= nxt_idx;                // Commit to the winner
            if (!eop_out) begin
              state_q <= ARB_LOCKED;         // Single-beat packets that leave now need no lock
            end
          end
        end
        ARB_LOCKED: begin
          if (eop_out) begin
            state_q <= ARB_SEARCH;           // Next search starts after the owner, so it advances
          end
        end
        default: state_q <= ARB_SEARCH;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/pkt_arb_regs.sv */
// Control registers beside the arbiter, reached through a strobed opcode port
// Writes land on the edge that samples the opcode, read data follows one cycle later
// Counters count accepted eop beats per channel and wrap on overflow
// A clear beats a done pulse for the same channel on the same edge
// The mask is written from the low PKT_ARB_NUM_IN bits of the write data
`timescale 1ns/1ns
`default_nettype none

`include "pkt_arb_defs.svh"

module pkt_arb_regs
  import pkt_arb_pkg::*;
(
  input  wire logic                          i_clk,
  input  wire logic                          i_rst,
  input  wire reg_op_e                       i_reg_op,    // One-cycle opcode strobe
  input  wire logic [`PKT_ARB_IDX_BITS-1:0]  i_reg_addr,  // Channel addressed by counter ops
  input  wire logic [`PKT_ARB_CNT_BITS-1:0]  i_reg_wdat,  // Write data for the mask
  output logic      [`PKT_ARB_CNT_BITS-1:0]  o_reg_rdat,  // Read data
  output logic                               o_reg_rvld,  // Read data valid, one cycle
  output logic      [`PKT_ARB_NUM_IN-1:0]    o_en_mask,   // Enable mask to the arbiter
  input  wire logic                          i_pkt_done,  // Eop accepted at the output
  input  wire logic [`PKT_ARB_IDX_BITS-1:0]  i_pkt_chan   // Channel of that eop
);

  localparam int NUM_IN = `PKT_ARB_NUM_IN;
  localparam int CNT_W  = `PKT_ARB_CNT_BITS;

  logic [NUM_IN-1:0]            mask_q;  // Channel enable mask
  logic [NUM_IN-1:0][CNT_W-1:0] cnt_q;   // Packet counters, one per channel

  assign o_en_mask = mask_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mask_q     <= '1;  // Every channel enabled out of reset
      o_reg_rvld <= 1'b0;
    end else begin
      o_reg_rvld <= (i_reg_op == REG_RD_MASK) || (i_reg_op == REG_RD_COUNT);
      if (i_reg_op == REG_WR_MASK) begin
        mask_q <= i_reg_wdat[NUM_IN-1:0];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt_q <= '0;
    end else begin
      for (int ch = 0; ch < NUM_IN; ch++) begin
        if ((i_reg_op == REG_CLR_COUNT) && (i_reg_addr == ch)) begin
          cnt_q[ch] <= '0;                 // Clear has priority over a done pulse
        end else if (i_pkt_done && (i_pkt_chan == ch)) begin
          cnt_q[ch] <= cnt_q[ch] + 1'b1;   // Wraps at the top
        end
      end
    end
  end

  // Read data shows the value held before this edge
  always_ff @(posedge i_clk) begin
    case (i_reg_op)
      REG_RD_MASK:  o_reg_rdat <= CNT_W'(mask_q);  // Zero-extended
      REG_RD_COUNT: o_reg_rdat <= cnt_q[i_reg_addr];
      default:      o_reg_rdat <= o_reg_rdat;
    endcase
  end

endmodule

`default_nettype wire

/* hw/pkt_arb_top.sv */
// Packet stream arbiter top level
// Each input goes through a one-beat slice, then a packet-locked round-robin arbiter
// The source channel is written into the top ctl bits of every output beat
// Register port controls the enable mask and reads per-channel packet counts
// Sources must hold beat and valid stable until ready is seen
`timescale 1ns/1ns
`default_nettype none

`include "pkt_arb_defs.svh"

module pkt_arb_top
  import pkt_arb_pkg::*;
(
  input  wire logic                           i_clk,
  input  wire logic                           i_rst,
  input  wire logic      [`PKT_ARB_NUM_IN-1:0] i_in_val,    // Input valids, one per channel
  input  wire pkt_beat_t [`PKT_ARB_NUM_IN-1:0] i_in_beat,   // Input beats, one per channel
  output logic           [`PKT_ARB_NUM_IN-1:0] o_in_rdy,    // Input readies, one per channel
  output logic                                o_out_val,   // Merged stream valid
  output pkt_beat_t                           o_out_beat,  // Merged stream beat, tagged
  input  wire logic                           i_out_rdy,   // Merged stream ready
  input  wire reg_op_e                        i_reg_op,    // Register opcode strobe
  input  wire logic [`PKT_ARB_IDX_BITS-1:0]   i_reg_addr,  // Register channel address
  input  wire logic [`PKT_ARB_CNT_BITS-1:0]   i_reg_wdat,  // Register write data
  output logic      [`PKT_ARB_CNT_BITS-1:0]   o_reg_rdat,  // Register read data
  output logic                                o_reg_rvld   // Register read data valid
);

  localparam int NUM_IN = `PKT_ARB_NUM_IN;
  localparam int IDX_W  = `PKT_ARB_IDX_BITS;

  logic      [NUM_IN-1:0] stg_val;   // Slice outputs towards the arbiter
  pkt_beat_t [NUM_IN-1:0] stg_beat;
  logic      [NUM_IN-1:0] stg_rdy;   // Arbiter ready back to the slices
  logic      [NUM_IN-1:0] en_mask;   // Mask from the register block
  logic                   pkt_done;  // Eop accepted at the output
  logic      [IDX_W-1:0]  pkt_chan;

  for (genvar g = 0; g < NUM_IN; g++) begin : g_stage
    pkt_in_stage #(
      .CHAN   (g)
    ) u_pkt_in_stage (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_val  (i_in_val[g]),
      .i_beat (i_in_beat[g]),
      .o_rdy  (o_in_rdy[g]),
      .o_val  (stg_val[g]),
      .o_beat (stg_beat[g]),
      .i_rdy  (stg_rdy[g])
    );
  end

  pkt_rr_arb u_pkt_rr_arb (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_val      (stg_val),
    .i_beat     (stg_beat),
    .o_rdy      (stg_rdy),
    .i_en_mask  (en_mask),
    .o_val      (o_out_val),
    .o_beat     (o_out_beat),
    .i_rdy      (i_out_rdy),
    .o_pkt_done (pkt_done),
    .o_pkt_chan (pkt_chan)
  );

  pkt_arb_regs u_pkt_arb_regs (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_reg_op   (i_reg_op),
    .i_reg_addr (i_reg_addr),
    .i_reg_wdat (i_reg_wdat),
    .o_reg_rdat (o_reg_rdat),
    .o_reg_rvld (o_reg_rvld),
    .o_en_mask  (en_mask),
    .i_pkt_done (pkt_done),
    .i_pkt_chan (pkt_chan)
  );

endmodule

`default_nettype wire

/* dv/pkt_arb_properties.sv */
// Concurrent checks on the merged output stream of pkt_arb_top, attached by bind
// Tag tracking assumes the output only carries whole tagged packets
`timescale 1ns/1ns
`default_nettype none

`include "pkt_arb_defs.svh"

module pkt_arb_properties
  import pkt_arb_pkg::*;
(
  input wire logic      i_clk,
  input wire logic      i_rst,
  input wire logic      o_out_val,
  input wire pkt_beat_t o_out_beat,
  input wire logic      i_out_rdy
);

  localparam int IDX_W   = `PKT_ARB_IDX_BITS;
  localparam int TAG_LSB = `PKT_ARB_TAG_LSB;

  logic             open_q;  // A packet has started but its eop has not left
  logic [IDX_W-1:0] tag_q;   // Tag of the open packet

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      open_q <= 1'b0;
    end else if (o_out_val && i_out_rdy) begin
      open_q <= ~o_out_beat.eop;                      // Closes on the eop beat
      if (o_out_beat.sop) begin
        tag_q <= o_out_beat.ctl[TAG_LSB +: IDX_W];
      end
    end
  end

  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_out_val && !i_out_rdy) |=> (o_out_val && $stable(o_out_beat)))
    else $error("output beat changed while stalled");

  a_tag_locked: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_out_val && open_q) |-> (o_out_beat.ctl[TAG_LSB +: IDX_W] == tag_q))
    else $error("tag changed inside a packet");

  a_reset_idle: assert property (@(posedge i_clk) i_rst |=> !o_out_val)
    else $error("output valid high right after reset");

endmodule

bind pkt_arb_top pkt_arb_properties u_pkt_arb_properties (.*);

`default_nettype wire

/* dv/pkt_arb_tb.sv */
// Seeded random testbench for pkt_arb_top with per-channel expected beat queues
// Phases cover random traffic, round-robin order, masking of channel 2 and the counters
// Stops at the first mismatch
`timescale 1ns/1ns
`default_nettype none

`include "pkt_arb_defs.svh"

module pkt_arb_tb
  import pkt_arb_pkg::*;
;

  localparam int NUM_IN  = `PKT_ARB_NUM_IN;
  localparam int IDX_W   = `PKT_ARB_IDX_BITS;
  localparam int TAG_LSB = `PKT_ARB_TAG_LSB;
  localparam int DEPTH   = 64;                 // Expected beats kept per channel

  logic i_clk, i_rst, i_out_rdy, o_out_val, o_reg_rvld;
  logic      [NUM_IN-1:0] i_in_val, o_in_rdy;
  pkt_beat_t [NUM_IN-1:0] i_in_beat;
  pkt_beat_t o_out_beat;
  reg_op_e   i_reg_op;
  logic [IDX_W-1:0] i_reg_addr;
  logic [`PKT_ARB_CNT_BITS-1:0] i_reg_wdat, o_reg_rdat;

  integer    seed = 32'hfeba_8cdd;
  pkt_beat_t exp_mem [NUM_IN][DEPTH];          // Circular expected queue per channel
  int        head [NUM_IN], tail [NUM_IN], left [NUM_IN], cnt_model [NUM_IN];
  logic      first [NUM_IN];
  logic      gen_en, backlog, rr_chk, blk2, have_last, in_pkt;
  int        last_tag, pkt_tag, pkt_total, err_cnt;

  pkt_arb_top u_pkt_arb_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;  // 40 ns period
  end

  task automatic abort_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("error %s expected %0h actual %0h", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  function automatic logic all_idle();
    for (int ch = 0; ch < NUM_IN; ch++) begin
      if (i_in_val[ch] || left[ch] != 0 || head[ch] != tail[ch]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Sources hold beat and valid until their transfer, then pick the next beat
  always @(posedge i_clk) begin : stream_drive
    pkt_beat_t b;
    logic      xfer;
    if (!i_rst) begin
      i_out_rdy <= ($random(seed) & 3) != 0;                // Ready about 3 cycles in 4
      for (int ch = 0; ch < NUM_IN; ch++) begin
        xfer = i_in_val[ch] && o_in_rdy[ch];
        if (xfer) begin
          b = i_in_beat[ch];
          b.ctl[TAG_LSB +: IDX_W] = ch[IDX_W-1:0];           // Stage stamps its channel number
          exp_mem[ch][tail[ch] % DEPTH] = b;
          tail[ch]++;
        end
        if (!i_in_val[ch] || xfer) begin
          if (left[ch] == 0 && gen_en && (backlog || ($random(seed) & 1))) begin
            left[ch]  = 1 + (($random(seed) & 32'h7fff_ffff) % 6);  // 1 to 6 beats
            first[ch] = 1'b1;
          end
          if (left[ch] != 0 && (backlog || ($random(seed) & 3) != 0)) begin
            b.sop = first[ch];
            b.eop = (left[ch] == 1);
            b.err = ($random(seed) & 15) == 0;                // Occasional error flag
            b.mod = $random(seed);
            b.ctl = $random(seed);
            b.dat = $random(seed);
            i_in_beat[ch] <= b;
            i_in_val[ch]  <= 1'b1;
            left[ch]--;
            first[ch] = 1'b0;
          end else begin
            i_in_val[ch] <= 1'b0;
          end
        end
      end
    end
  end

  // Compares each output beat against the queue its tag names
  always @(posedge i_clk) begin : out_monitor
    pkt_beat_t a, e;
    int        t;
    if (!i_rst && o_out_val && i_out_rdy) begin
      a = o_out_beat;
      t = a.ctl[TAG_LSB +: IDX_W];
      if (head[t] == tail[t]) begin
        abort_run("an output beat arrived for a channel with nothing queued");
      end else begin
        e = exp_mem[t][head[t] % DEPTH];
        head[t]++;
        check("beat_sop", e.sop, a.sop);
        check("beat_eop", e.eop, a.eop);
        check("beat_err", e.err, a.err);
        check("beat_mod", e.mod, a.mod);
        check("beat_ctl", e.ctl, a.ctl);
        check("beat_dat", e.dat, a.dat);
        if (a.sop) begin
          check("atomic_no_open_packet", 0, in_pkt);
          if (rr_chk && have_last) check("rr_order", (last_tag + 1) % NUM_IN, t);
          if (blk2 && t == 2) abort_run("masked channel 2 started a new packet");
          last_tag  = t;
          have_last = 1'b1;
          in_pkt    = 1'b1;
          pkt_tag   = t;
        end else begin
          check("atomic_open_packet", 1, in_pkt);
          check("atomic_tag", pkt_tag, t);
        end
        if (a.eop) begin
          in_pkt = 1'b0;
          cnt_model[t]++;
          pkt_total++;
        end
      end
    end
  end

  task automatic reg_strobe(input reg_op_e op, input int addr, input int wdat);
    @(posedge i_clk);
    i_reg_op   <= op;
    i_reg_addr <= addr[IDX_W-1:0];
    i_reg_wdat <= wdat[`PKT_ARB_CNT_BITS-1:0];
    @(posedge i_clk);                                        // DUT samples the opcode here
    i_reg_op   <= REG_NOP;
  endtask

  task automatic reg_read(input string name, input reg_op_e op, input int addr, input int exp);
    int n;
    reg_strobe(op, addr, 0);
    n = 0;
    do begin
      @(posedge i_clk);
      n++;
    end while (!o_reg_rvld && n < 20);
    if (!o_reg_rvld) abort_run("register read data never became valid");
    check({name, "_latency"}, 1, n);
    check(name, exp, o_reg_rdat);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (!all_idle() && n < 5000) begin
      @(posedge i_clk);
      n++;
    end
    if (!all_idle()) abort_run("traffic did not drain in time");
  endtask

  task automatic wait_packets(input int cnt);
    int n, target;
    n      = 0;
    target = pkt_total + cnt;
    while (pkt_total < target && n < 20000) begin
      @(posedge i_clk);
      n++;
    end
    if (pkt_total < target) abort_run("too few packets reached the output");
  endtask

  initial begin : main
    int run;
    i_rst = 1'b1;
    i_in_val = '0;
    i_in_beat = '0;
    i_out_rdy = 1'b0;
    i_reg_op = REG_NOP;
    i_reg_addr = '0;
    i_reg_wdat = '0;
    {gen_en, backlog, rr_chk, blk2, have_last, in_pkt} = '0;
    {pkt_total, err_cnt, last_tag, pkt_tag} = '0;
    for (int ch = 0; ch < NUM_IN; ch++) begin
      {head[ch], tail[ch], left[ch], cnt_model[ch]} = '0;
      first[ch] = 1'b0;
    end
    repeat (10) @(posedge i_clk);
    i_rst <= 1'b0;
    gen_en = 1'b1;                                           // Random traffic and back-pressure
    wait_packets(300);
    gen_en = 1'b0;
    wait_drained();
    backlog   = 1'b1;                                        // Every channel always has data
    gen_en    = 1'b1;
    have_last = 1'b0;
    rr_chk    = 1'b1;
    wait_packets(200);
    rr_chk = 1'b0;
    reg_strobe(REG_WR_MASK, 0, 4'b1011);                     // Block channel 2
    wait_packets(1);                                         // A packet locked before the write ends first
    blk2 = 1'b1;
    run  = 0;
    for (int n = 0; n < 3000 && run < 16; n++) begin
      @(posedge i_clk);
      run = (!o_in_rdy[2] && i_in_val[2]) ? run + 1 : 0;     // Held data with no ready
    end
    if (run < 16) abort_run("channel 2 kept accepting data while masked");
    wait_packets(60);
    blk2 = 1'b0;
    reg_strobe(REG_WR_MASK, 0, 4'hf);
    wait_packets(60);
    backlog = 1'b0;
    gen_en  = 1'b0;
    wait_drained();
    repeat (4) @(posedge i_clk);
    for (int ch = 0; ch < NUM_IN; ch++) begin
      reg_read("rd_count", REG_RD_COUNT, ch, cnt_model[ch] & 32'hffff);
    end
    reg_strobe(REG_CLR_COUNT, 0, 0);
    reg_strobe(REG_CLR_COUNT, 2, 0);
    cnt_model[0] = 0;
    cnt_model[2] = 0;
    for (int ch = 0; ch < NUM_IN; ch++) begin
      reg_read("rd_count_cleared", REG_RD_COUNT, ch, cnt_model[ch] & 32'hffff);
    end
    reg_strobe(REG_WR_MASK, 0, 4'b0110);
    reg_read("rd_mask", REG_RD_MASK, 0, 4'b0110);
    reg_strobe(REG_WR_MASK, 0, 4'hf);
    reg_read("rd_mask_restored", REG_RD_MASK, 0, 4'hf);
    if (err_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "errors were counted");
    end
  end

endmodule

`default_nettype wire

/* pkt_arb.f */
+incdir+hw
hw/pkt_arb_pkg.sv
hw/pkt_in_stage.sv
hw/pkt_rr_arb.sv
hw/pkt_arb_regs.sv
hw/pkt_arb_top.sv
dv/pkt_arb_properties.sv
dv/pkt_arb_tb.sv
